//--- rtl/core_settings.svh
// Global build settings of the integer core
// Pipeline depth, register word width and register index width

`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// Six stages from fetch 1 through writeback
`define CORE_NUM_STAGES 6

// RV32 register width
`define CORE_XLEN 32

// Index into the 32 general purpose registers
`define CORE_REG_IDX_W 5

`endif

//--- rtl/core_pkg.sv
// Shared types of the integer core
// Register word and index types, stage index names
// Configuration word bit positions

`include "core_settings.svh"

package core_pkg;

    // One general purpose register value
    typedef logic [`CORE_XLEN-1:0] word_t;

    // General purpose register index
    // Register 0 is hardwired to zero
    typedef logic [`CORE_REG_IDX_W-1:0] reg_idx_t;

    // Stage positions inside the stall and flush vectors
    // Lower index means younger instruction
    typedef enum logic [2:0] {
        STAGE_F1 = 3'd0,
        STAGE_F2 = 3'd1,
        STAGE_D  = 3'd2,
        STAGE_E1 = 3'd3,
        STAGE_E2 = 3'd4,
        STAGE_W  = 3'd5
    } stage_e;

    // Configuration write word layout
    // Bypass enable reads back
    localparam int unsigned CFG_BYPASS_EN_BIT = 0;

    // Cache and TLB flush command
    // Write only and reads back as zero
    localparam int unsigned CFG_CACHE_FLUSH_BIT = 1;

endpackage : core_pkg

//--- rtl/core_tghm_cfg.sv
// Hazard controller configuration registers
// Bypass enable bit and one-shot global cache flush

`timescale 1ns/10ps

module core_tghm_cfg (
    // Clock and reset
    input  logic       i_clk,
    input  logic       i_rst_n,

    // Configuration write port
    input  logic       i_cfg_wen,
    input  logic [1:0] i_cfg_wdata,

    // Readback of the current configuration
    output logic [1:0] o_cfg_rdata,

    // Controls toward the rest of the controller
    output logic       o_bypass_en,
    output logic       o_global_cache_flush
);

    // Current bypass setting
    logic bypass_en_q;

    // One-shot flush flop
    logic cache_flush_q;

    // Flush request seen on this write
    logic cache_flush_req;

    // Only a write that carries the command bit requests a flush
    assign cache_flush_req = i_cfg_wen & i_cfg_wdata[core_pkg::CFG_CACHE_FLUSH_BIT];

    // Bypass enable register
    // Comes out of reset with forwarding on
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            bypass_en_q <= 1'b1;
        end else if (i_cfg_wen) begin
            bypass_en_q <= i_cfg_wdata[core_pkg::CFG_BYPASS_EN_BIT];
        end
    end

    // Flush pulse
    // Loaded by the write and cleared again on the next edge
    // Back to back flush writes give one cycle each
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            cache_flush_q <= 1'b0;
        end else begin
            cache_flush_q <= cache_flush_req;
        end
    end

    // Readback word
    always_comb begin
        o_cfg_rdata = '0;
        o_cfg_rdata[core_pkg::CFG_BYPASS_EN_BIT] = bypass_en_q;
        // Flush command bit is never stored
        o_cfg_rdata[core_pkg::CFG_CACHE_FLUSH_BIT] = 1'b0;
    end

    // Outputs straight from the flops
    assign o_bypass_en          = bypass_en_q;
    assign o_global_cache_flush = cache_flush_q;

endmodule : core_tghm_cfg

//--- rtl/core_tghm_bypass.sv
// Decode stage operand forwarding
// Youngest producer wins among E1, E2 and W
// Raises the decode hazard stall on load-use or when bypassing is off

`timescale 1ns/10ps

module core_tghm_bypass (
    // Configuration
    input  logic              i_bypass_en,

    // Execute 1 producer
    input  logic              i_stage_e1_rd_wen,
    input  core_pkg::reg_idx_t i_stage_e1_rd_idx,
    input  core_pkg::word_t   i_stage_e1_rd_wdata,
    input  logic              i_stage_e1_is_load,

    // Execute 2 producer
    input  logic              i_stage_e2_rd_wen,
    input  core_pkg::reg_idx_t i_stage_e2_rd_idx,
    input  core_pkg::word_t   i_stage_e2_rd_wdata,

    // Writeback producer
    input  logic              i_stage_w_rd_wen,
    input  core_pkg::reg_idx_t i_stage_w_rd_idx,
    input  core_pkg::word_t   i_stage_w_rd_wdata,

    // Decode source registers
    input  core_pkg::reg_idx_t i_stage_d_rs1_idx,
    input  core_pkg::reg_idx_t i_stage_d_rs2_idx,

    // Forwarding results toward decode
    output logic              o_stage_d_bypass_rs1,
    output logic              o_stage_d_bypass_rs2,
    output core_pkg::word_t   o_stage_d_bypass_rs1_rdata,
    output core_pkg::word_t   o_stage_d_bypass_rs2_rdata,

    // Decode must hold
    output logic              o_hazard_stall_d
);

    // Two source operands handled by the same loop
    localparam int NUM_SRC = 2;

    // Source index per operand
    core_pkg::reg_idx_t rs_idx [NUM_SRC];

    // Per operand producer matches
    logic hit_e1 [NUM_SRC];
    logic hit_e2 [NUM_SRC];
    logic hit_w  [NUM_SRC];

    // Per operand results
    logic            fwd     [NUM_SRC];
    core_pkg::word_t fwd_data[NUM_SRC];
    logic            hazard  [NUM_SRC];

    assign rs_idx[0] = i_stage_d_rs1_idx;
    assign rs_idx[1] = i_stage_d_rs2_idx;

    // Producer match
    // x0 never matches since its value is always zero
    always_comb begin
        for (int s = 0; s < NUM_SRC; s++) begin
            hit_e1[s] = i_stage_e1_rd_wen && (i_stage_e1_rd_idx == rs_idx[s])
                        && (rs_idx[s] != '0);
            hit_e2[s] = i_stage_e2_rd_wen && (i_stage_e2_rd_idx == rs_idx[s])
                        && (rs_idx[s] != '0);
            hit_w[s]  = i_stage_w_rd_wen && (i_stage_w_rd_idx == rs_idx[s])
                        && (rs_idx[s] != '0);
        end
    end

    // Forward selection
    always_comb begin
        for (int s = 0; s < NUM_SRC; s++) begin
            fwd[s]      = 1'b0;
            fwd_data[s] = '0;
            hazard[s]   = 1'b0;

            if (i_bypass_en) begin
                // E1 is the youngest producer so it is checked first
                if (hit_e1[s]) begin
                    if (i_stage_e1_is_load) begin
                        // Load data only shows up later so decode waits
                        hazard[s] = 1'b1;
                    end else begin
                        fwd[s]      = 1'b1;
                        fwd_data[s] = i_stage_e1_rd_wdata;
                    end
                end else if (hit_e2[s]) begin
                    fwd[s]      = 1'b1;
                    fwd_data[s] = i_stage_e2_rd_wdata;
                end else if (hit_w[s]) begin
                    fwd[s]      = 1'b1;
                    fwd_data[s] = i_stage_w_rd_wdata;
                end
            end else begin
                // No forwarding path
                // Decode waits until every producer has retired
                hazard[s] = hit_e1[s] | hit_e2[s] | hit_w[s];
            end
        end
    end

    // Outputs
    assign o_stage_d_bypass_rs1       = fwd[0];
    assign o_stage_d_bypass_rs2       = fwd[1];
    assign o_stage_d_bypass_rs1_rdata = fwd_data[0];
    assign o_stage_d_bypass_rs2_rdata = fwd_data[1];

    // Either operand holds decode
    assign o_hazard_stall_d = hazard[0] | hazard[1];

endmodule : core_tghm_bypass

//--- rtl/core_tghm_stall.sv
// Pipeline stall chain and flush vector
// Back-pressure from stage readiness plus the decode hazard
// Redirect flush and bubble insertion into execute 1

`timescale 1ns/10ps

`include "core_settings.svh"

module core_tghm_stall (
    // Per stage readiness
    input  logic [`CORE_NUM_STAGES-1:0] i_stage_ready,

    // Decode hazard from the bypass block
    input  logic                        i_hazard_stall_d,

    // Control flow redirect from execute 2
    input  logic                        i_redirect,

    // Per stage controls
    output logic [`CORE_NUM_STAGES-1:0] o_stage_stall,
    output logic [`CORE_NUM_STAGES-1:0] o_stage_flush
);

    // Hazard after redirect masking
    logic hazard_eff;

    // Stall chain from writeback back toward fetch 1
    logic [`CORE_NUM_STAGES-1:0] stall_chain;

    // Bubble into execute 1 on a decode hold
    logic bubble_e1;

    // Redirect wins
    // Stages it flushes do not hold for the hazard
    assign hazard_eff = i_hazard_stall_d & ~i_redirect;

    // Stall of a stage follows the stage in front of it
    always_comb begin
        stall_chain = '0;

        // Writeback always retires
        stall_chain[core_pkg::STAGE_W] = 1'b0;

        for (int ii = int'(core_pkg::STAGE_E2); ii >= int'(core_pkg::STAGE_F1); ii--) begin
            stall_chain[ii] = stall_chain[ii+1] | ~i_stage_ready[ii+1];

            // Front three stages also hold for the decode hazard
            if (ii <= int'(core_pkg::STAGE_D)) begin
                stall_chain[ii] = stall_chain[ii] | hazard_eff;
            end
        end
    end

    // E1 stall has no hazard term
    // A stalled E1 keeps its instruction so no bubble is needed
    assign bubble_e1 = hazard_eff & ~stall_chain[core_pkg::STAGE_E1];

    // Flush vector
    always_comb begin
        o_stage_flush = '0;

        // Wrong path instructions from fetch 1 up to execute 1
        for (int ii = int'(core_pkg::STAGE_F1); ii <= int'(core_pkg::STAGE_E1); ii++) begin
            o_stage_flush[ii] = i_redirect;
        end

        o_stage_flush[core_pkg::STAGE_E1] = i_redirect | bubble_e1;

        // Older stages keep their instructions
        o_stage_flush[core_pkg::STAGE_E2] = 1'b0;
        o_stage_flush[core_pkg::STAGE_W]  = 1'b0;
    end

    assign o_stage_stall = stall_chain;

endmodule : core_tghm_stall

//--- rtl/core_tghm.sv
// Hazard controller top level
// Configuration, decode bypass and stall/flush blocks

`timescale 1ns/10ps

`include "core_settings.svh"

module core_tghm (
    // Clock and reset
    input  logic                        i_clk,
    input  logic                        i_rst_n,

    // Back-pressure
    input  logic [`CORE_NUM_STAGES-1:0] i_stage_ready,
    output logic [`CORE_NUM_STAGES-1:0] o_stage_stall,
    output logic [`CORE_NUM_STAGES-1:0] o_stage_flush,

    // Execute 1 producer
    input  logic                        i_stage_e1_rd_wen,
    input  core_pkg::reg_idx_t          i_stage_e1_rd_idx,
    input  core_pkg::word_t             i_stage_e1_rd_wdata,
    input  logic                        i_stage_e1_is_load,

    // Execute 2 producer
    input  logic                        i_stage_e2_rd_wen,
    input  core_pkg::reg_idx_t          i_stage_e2_rd_idx,
    input  core_pkg::word_t             i_stage_e2_rd_wdata,

    // Writeback producer
    input  logic                        i_stage_w_rd_wen,
    input  core_pkg::reg_idx_t          i_stage_w_rd_idx,
    input  core_pkg::word_t             i_stage_w_rd_wdata,

    // Decode sources
    input  core_pkg::reg_idx_t          i_stage_d_rs1_idx,
    input  core_pkg::reg_idx_t          i_stage_d_rs2_idx,

    // General purpose register bypass into decode
    output logic                        o_stage_d_bypass_rs1,
    output logic                        o_stage_d_bypass_rs2,
    output core_pkg::word_t             o_stage_d_bypass_rs1_rdata,
    output core_pkg::word_t             o_stage_d_bypass_rs2_rdata,

    // Redirect from execute 2
    input  logic                        i_redirect,

    // Configuration access
    input  logic                        i_cfg_wen,
    input  logic [1:0]                  i_cfg_wdata,
    output logic [1:0]                  o_cfg_rdata,

    // Flush all caches and TLBs
    output logic                        o_global_cache_flush
);

    // Forwarding enabled by configuration
    logic bypass_en;

    // Decode has to hold
    logic hazard_stall_d;

    // Configuration registers
    core_tghm_cfg u_cfg (
        .i_clk                (i_clk),
        .i_rst_n              (i_rst_n),
        .i_cfg_wen            (i_cfg_wen),
        .i_cfg_wdata          (i_cfg_wdata),
        .o_cfg_rdata          (o_cfg_rdata),
        .o_bypass_en          (bypass_en),
        .o_global_cache_flush (o_global_cache_flush)
    );

    // Operand forwarding and hazard detection
    core_tghm_bypass u_bypass (
        .i_bypass_en                (bypass_en),
        .i_stage_e1_rd_wen          (i_stage_e1_rd_wen),
        .i_stage_e1_rd_idx          (i_stage_e1_rd_idx),
        .i_stage_e1_rd_wdata        (i_stage_e1_rd_wdata),
        .i_stage_e1_is_load         (i_stage_e1_is_load),
        .i_stage_e2_rd_wen          (i_stage_e2_rd_wen),
        .i_stage_e2_rd_idx          (i_stage_e2_rd_idx),
        .i_stage_e2_rd_wdata        (i_stage_e2_rd_wdata),
        .i_stage_w_rd_wen           (i_stage_w_rd_wen),
        .i_stage_w_rd_idx           (i_stage_w_rd_idx),
        .i_stage_w_rd_wdata         (i_stage_w_rd_wdata),
        .i_stage_d_rs1_idx          (i_stage_d_rs1_idx),
        .i_stage_d_rs2_idx          (i_stage_d_rs2_idx),
        .o_stage_d_bypass_rs1       (o_stage_d_bypass_rs1),
        .o_stage_d_bypass_rs2       (o_stage_d_bypass_rs2),
        .o_stage_d_bypass_rs1_rdata (o_stage_d_bypass_rs1_rdata),
        .o_stage_d_bypass_rs2_rdata (o_stage_d_bypass_rs2_rdata),
        .o_hazard_stall_d           (hazard_stall_d)
    );

    // Stall chain and flush vector
    core_tghm_stall u_stall (
        .i_stage_ready    (i_stage_ready),
        .i_hazard_stall_d (hazard_stall_d),
        .i_redirect       (i_redirect),
        .o_stage_stall    (o_stage_stall),
        .o_stage_flush    (o_stage_flush)
    );

endmodule : core_tghm

//--- verification/core_tghm_checker.sv
// Reference model of the hazard controller
// Configuration state, expected forwarding, stall and flush vectors
// Compares every DUT output once per cycle

`timescale 1ns/10ps

`include "core_settings.svh"

module core_tghm_checker (
    input  logic                        i_clk,
    input  logic                        i_rst_n,

    // Stimulus as seen by the DUT
    input  logic [`CORE_NUM_STAGES-1:0] i_stage_ready,
    input  logic                        i_stage_e1_rd_wen,
    input  core_pkg::reg_idx_t          i_stage_e1_rd_idx,
    input  core_pkg::word_t             i_stage_e1_rd_wdata,
    input  logic                        i_stage_e1_is_load,
    input  logic                        i_stage_e2_rd_wen,
    input  core_pkg::reg_idx_t          i_stage_e2_rd_idx,
    input  core_pkg::word_t             i_stage_e2_rd_wdata,
    input  logic                        i_stage_w_rd_wen,
    input  core_pkg::reg_idx_t          i_stage_w_rd_idx,
    input  core_pkg::word_t             i_stage_w_rd_wdata,
    input  core_pkg::reg_idx_t          i_stage_d_rs1_idx,
    input  core_pkg::reg_idx_t          i_stage_d_rs2_idx,
    input  logic                        i_redirect,
    input  logic                        i_cfg_wen,
    input  logic [1:0]                  i_cfg_wdata,

    // Observed DUT outputs
    input  logic [`CORE_NUM_STAGES-1:0] i_stage_stall,
    input  logic [`CORE_NUM_STAGES-1:0] i_stage_flush,
    input  logic                        i_stage_d_bypass_rs1,
    input  logic                        i_stage_d_bypass_rs2,
    input  core_pkg::word_t             i_stage_d_bypass_rs1_rdata,
    input  core_pkg::word_t             i_stage_d_bypass_rs2_rdata,
    input  logic [1:0]                  i_cfg_rdata,
    input  logic                        i_global_cache_flush,

    // Running count of wrong values
    output int                          o_err_count
);

    localparam int NS = `CORE_NUM_STAGES;

    // Model of the configuration state
    logic bypass_m;
    logic flush_m;

    // Expected values for the current cycle
    logic                      fwd1_e;
    logic                      fwd2_e;
    core_pkg::word_t           data1_e;
    core_pkg::word_t           data2_e;
    logic                      hz1;
    logic                      hz2;
    logic                      hz_e;
    logic [NS-1:0]             stall_e;
    logic [NS-1:0]             flush_e;

    initial o_err_count = 0;

    // Write lands on the edge
    // Flush command lives for one cycle
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            bypass_m <= 1'b1;
            flush_m  <= 1'b0;
        end else begin
            if (i_cfg_wen) begin
                bypass_m <= i_cfg_wdata[core_pkg::CFG_BYPASS_EN_BIT];
            end
            flush_m <= i_cfg_wen && i_cfg_wdata[core_pkg::CFG_CACHE_FLUSH_BIT];
        end
    end

    // Youngest matching producer for one source
    // x0 never matches
    task automatic resolve_source(input core_pkg::reg_idx_t rs, output logic fwd,
                                  output core_pkg::word_t data, output logic hz);
        fwd  = 1'b0;
        data = '0;
        hz   = 1'b0;
        if (rs != '0) begin
            if (i_stage_e1_rd_wen && (i_stage_e1_rd_idx == rs)) begin
                // No forwarding path or load result not there yet
                if (!bypass_m || i_stage_e1_is_load) begin
                    hz = 1'b1;
                end else begin
                    fwd  = 1'b1;
                    data = i_stage_e1_rd_wdata;
                end
            end else if (i_stage_e2_rd_wen && (i_stage_e2_rd_idx == rs)) begin
                fwd  = bypass_m;
                data = bypass_m ? i_stage_e2_rd_wdata : '0;
                hz   = !bypass_m;
            end else if (i_stage_w_rd_wen && (i_stage_w_rd_idx == rs)) begin
                fwd  = bypass_m;
                data = bypass_m ? i_stage_w_rd_wdata : '0;
                hz   = !bypass_m;
            end
        end
    endtask

    // Stage i holds if any older stage is not ready
    // Front stages also hold on a hazard
    task automatic expect_pipeline_controls();
        for (int i = 0; i < NS; i++) begin
            stall_e[i] = 1'b0;
            for (int j = i + 1; j < NS; j++) begin
                if (!i_stage_ready[j]) begin
                    stall_e[i] = 1'b1;
                end
            end
            if ((i <= int'(core_pkg::STAGE_D)) && hz_e && !i_redirect) begin
                stall_e[i] = 1'b1;
            end
        end
        flush_e = '0;
        if (i_redirect) begin
            for (int i = int'(core_pkg::STAGE_F1); i <= int'(core_pkg::STAGE_E1); i++) begin
                flush_e[i] = 1'b1;
            end
        end else if (hz_e && !stall_e[core_pkg::STAGE_E1]) begin
            // Bubble behind the held decode
            flush_e[core_pkg::STAGE_E1] = 1'b1;
        end
    endtask

    task automatic compare_field(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
        if (act !== exp) begin
            o_err_count++;
            $display("mismatch %s: expected 0x%0h actual 0x%0h at %0t", name, exp, act, $time);
        end
    endtask

    // Inputs change shortly after the rising edge and have settled by mid-cycle
    always @(negedge i_clk) begin
        if (i_rst_n) begin
            resolve_source(i_stage_d_rs1_idx, fwd1_e, data1_e, hz1);
            resolve_source(i_stage_d_rs2_idx, fwd2_e, data2_e, hz2);
            hz_e = hz1 | hz2;
            expect_pipeline_controls();
            compare_field("o_stage_stall", stall_e, i_stage_stall);
            compare_field("o_stage_flush", flush_e, i_stage_flush);
            compare_field("o_stage_d_bypass_rs1", fwd1_e, i_stage_d_bypass_rs1);
            compare_field("o_stage_d_bypass_rs2", fwd2_e, i_stage_d_bypass_rs2);
            compare_field("o_stage_d_bypass_rs1_rdata", data1_e, i_stage_d_bypass_rs1_rdata);
            compare_field("o_stage_d_bypass_rs2_rdata", data2_e, i_stage_d_bypass_rs2_rdata);
            compare_field("o_cfg_rdata", {1'b0, bypass_m}, i_cfg_rdata);
            compare_field("o_global_cache_flush", flush_m, i_global_cache_flush);
        end
    end

endmodule : core_tghm_checker

//--- verification/tb_core_tghm.sv
// Testbench of the hazard controller
// Clock, reset, random stimulus per test, watchdog, DUT and checker

`timescale 1ns/10ps

`include "core_settings.svh"

module tb_core_tghm;

    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 3;
    localparam int T1_CYCLES    = 4;
    localparam int T2_CYCLES    = 60;
    localparam int T3_CYCLES    = 120;
    localparam int T4_RUN       = 40;
    localparam int T5_CYCLES    = 120;
    localparam int FLUSH_WINDOW = 4;
    // Two flush writes with their windows, plus the restoring write
    localparam int T6_CYCLES    = 2 * (1 + FLUSH_WINDOW) + 1;
    localparam int TOTAL_CYCLES = RESET_CYCLES + T1_CYCLES + T2_CYCLES + T3_CYCLES
                                  + 2 * (T4_RUN + 1) + T5_CYCLES + T6_CYCLES;
    localparam int MARGIN       = 20;

    logic                        i_clk;
    logic                        i_rst_n;
    logic [`CORE_NUM_STAGES-1:0] i_stage_ready;
    logic                        i_stage_e1_rd_wen;
    core_pkg::reg_idx_t          i_stage_e1_rd_idx;
    core_pkg::word_t             i_stage_e1_rd_wdata;
    logic                        i_stage_e1_is_load;
    logic                        i_stage_e2_rd_wen;
    core_pkg::reg_idx_t          i_stage_e2_rd_idx;
    core_pkg::word_t             i_stage_e2_rd_wdata;
    logic                        i_stage_w_rd_wen;
    core_pkg::reg_idx_t          i_stage_w_rd_idx;
    core_pkg::word_t             i_stage_w_rd_wdata;
    core_pkg::reg_idx_t          i_stage_d_rs1_idx;
    core_pkg::reg_idx_t          i_stage_d_rs2_idx;
    logic                        i_redirect;
    logic                        i_cfg_wen;
    logic [1:0]                  i_cfg_wdata;
    logic [`CORE_NUM_STAGES-1:0] o_stage_stall;
    logic [`CORE_NUM_STAGES-1:0] o_stage_flush;
    logic                        o_stage_d_bypass_rs1;
    logic                        o_stage_d_bypass_rs2;
    core_pkg::word_t             o_stage_d_bypass_rs1_rdata;
    core_pkg::word_t             o_stage_d_bypass_rs2_rdata;
    logic [1:0]                  o_cfg_rdata;
    logic                        o_global_cache_flush;

    integer seed;
    int     chk_errors;
    int     tb_errors;
    int     test_num;
    int     pass_tests;
    int     fail_tests;
    int     errs;

    core_tghm uut (.*);

    core_tghm_checker chk (
        .i_stage_stall              (o_stage_stall),
        .i_stage_flush              (o_stage_flush),
        .i_stage_d_bypass_rs1       (o_stage_d_bypass_rs1),
        .i_stage_d_bypass_rs2       (o_stage_d_bypass_rs2),
        .i_stage_d_bypass_rs1_rdata (o_stage_d_bypass_rs1_rdata),
        .i_stage_d_bypass_rs2_rdata (o_stage_d_bypass_rs2_rdata),
        .i_cfg_rdata                (o_cfg_rdata),
        .i_global_cache_flush       (o_global_cache_flush),
        .o_err_count                (chk_errors),
        .*
    );

    initial begin
        i_clk = 1'b0;
        forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
    end

    // Upper bound on the whole run
    initial begin
        #((TOTAL_CYCLES + MARGIN) * CLK_PERIOD);
        $display("watchdog expired after %0d cycles without the tests completing",
                 TOTAL_CYCLES + MARGIN);
        $display("Simulation finished: FAIL");
        $finish;
    end

    function automatic int total_errors();
        return chk_errors + tb_errors;
    endfunction

    task automatic wait_drive_slot();
        @(posedge i_clk);
        #5;
    endtask

    // All ready, no producers, no redirect, no config access
    task automatic drive_idle();
        i_stage_ready       = '1;
        i_stage_e1_rd_wen   = 1'b0;
        i_stage_e1_rd_idx   = '0;
        i_stage_e1_rd_wdata = '0;
        i_stage_e1_is_load  = 1'b0;
        i_stage_e2_rd_wen   = 1'b0;
        i_stage_e2_rd_idx   = '0;
        i_stage_e2_rd_wdata = '0;
        i_stage_w_rd_wen    = 1'b0;
        i_stage_w_rd_idx    = '0;
        i_stage_w_rd_wdata  = '0;
        i_stage_d_rs1_idx   = '0;
        i_stage_d_rs2_idx   = '0;
        i_redirect          = 1'b0;
        i_cfg_wen           = 1'b0;
        i_cfg_wdata         = '0;
    endtask

    // Indices kept to x0..x3 so matches happen often
    task automatic randomize_inputs(input bit with_producers, input bit with_redirect);
        drive_idle();
        // Roughly three in four stages ready
        i_stage_ready = $random(seed) | $random(seed);
        if (with_producers) begin
            i_stage_e1_rd_wen   = $random(seed);
            i_stage_e1_rd_idx   = $random(seed) & 3;
            i_stage_e1_rd_wdata = $random(seed);
            i_stage_e1_is_load  = $random(seed);
            i_stage_e2_rd_wen   = $random(seed);
            i_stage_e2_rd_idx   = $random(seed) & 3;
            i_stage_e2_rd_wdata = $random(seed);
            i_stage_w_rd_wen    = $random(seed);
            i_stage_w_rd_idx    = $random(seed) & 3;
            i_stage_w_rd_wdata  = $random(seed);
            i_stage_d_rs1_idx   = $random(seed) & 3;
            i_stage_d_rs2_idx   = $random(seed) & 3;
        end
        if (with_redirect) begin
            i_redirect = (($random(seed) & 3) == 0);
        end
    endtask

    task automatic write_config(input logic [1:0] data);
        wait_drive_slot();
        drive_idle();
        i_cfg_wen   = 1'b1;
        i_cfg_wdata = data;
    endtask

    // Flush pulse cycles after a write
    task automatic count_flush_pulses();
        int n;
        n = 0;
        repeat (FLUSH_WINDOW) begin
            wait_drive_slot();
            drive_idle();
            @(negedge i_clk);
            if (o_global_cache_flush) begin
                n++;
            end
        end
        if (n != 1) begin
            tb_errors++;
            $display("cache flush pulse was high for %0d cycles instead of one", n);
        end
    endtask

    // Lets the last cycle be checked, then reports the test
    task automatic close_test(input string name, input int errs_before);
        @(negedge i_clk);
        #1;
        test_num++;
        if (total_errors() == errs_before) begin
            pass_tests++;
            $display("test %0d %s: pass", test_num, name);
        end else begin
            fail_tests++;
            $display("test %0d %s: fail, %0d errors", test_num, name,
                     total_errors() - errs_before);
        end
    endtask

    initial begin
        seed       = 40179;
        tb_errors  = 0;
        test_num   = 0;
        pass_tests = 0;
        fail_tests = 0;
        i_rst_n    = 1'b0;
        drive_idle();
        repeat (RESET_CYCLES) @(posedge i_clk);
        #5 i_rst_n = 1'b1;

        errs = total_errors();
        repeat (T1_CYCLES) begin
            wait_drive_slot();
            drive_idle();
        end
        close_test("reset defaults", errs);

        errs = total_errors();
        repeat (T2_CYCLES) begin
            wait_drive_slot();
            randomize_inputs(1'b0, 1'b0);
        end
        close_test("back-pressure chain", errs);

        errs = total_errors();
        repeat (T3_CYCLES) begin
            wait_drive_slot();
            randomize_inputs(1'b1, 1'b0);
        end
        close_test("forwarding with bypass on", errs);

        errs = total_errors();
        write_config(2'b00);
        repeat (T4_RUN) begin
            wait_drive_slot();
            randomize_inputs(1'b1, 1'b0);
        end
        write_config(2'b01);
        repeat (T4_RUN) begin
            wait_drive_slot();
            randomize_inputs(1'b1, 1'b0);
        end
        close_test("bypass off and back on", errs);

        errs = total_errors();
        repeat (T5_CYCLES) begin
            wait_drive_slot();
            randomize_inputs(1'b1, 1'b1);
            // Load-use on rs1 in about half the cycles
            if ($random(seed) & 1) begin
                i_stage_d_rs1_idx  = 5'd1 + ($random(seed) & 3);
                i_stage_e1_rd_idx  = i_stage_d_rs1_idx;
                i_stage_e1_rd_wen  = 1'b1;
                i_stage_e1_is_load = 1'b1;
            end
        end
        close_test("redirect against load-use", errs);

        errs = total_errors();
        write_config(2'b11);
        count_flush_pulses();
        write_config(2'b10);
        count_flush_pulses();
        write_config(2'b01);
        close_test("cache flush pulse", errs);

        $display("tests passed %0d failed %0d, errors %0d", pass_tests, fail_tests,
                 total_errors());
        if (fail_tests == 0 && total_errors() == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule : tb_core_tghm

//--- list.f
+incdir+rtl
rtl/core_pkg.sv
rtl/core_tghm_cfg.sv
rtl/core_tghm_bypass.sv
rtl/core_tghm_stall.sv
rtl/core_tghm.sv
verification/core_tghm_checker.sv
verification/tb_core_tghm.sv
